// ==== sources.f ====
+incdir+src
src/scrollPkg.sv
src/laneField.sv
src/collisionCheck.sv
src/scrollTop.sv
testbench/scrollTop_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lane field testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    -f sources.f \
    --top-module scrollTop_tb \
    -o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== testbench/scrollTop_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scrollField_params.svh"

module scrollTop_tb;

    import scrollPkg::*;

    localparam int NUM_LANES      = `SCROLL_NUM_LANES;
    localparam int NUM_BARS       = `SCROLL_BARS_PER_LANE;
    localparam int SCREEN_W       = `SCROLL_SCREEN_W;
    localparam int ROW_H          = `SCROLL_ROW_H;
    localparam int PLAYER_SIZE    = `SCROLL_PLAYER_SIZE;
    localparam int TIMEOUT_CYCLES = 3000;

    logic                       btnClk = 1'b0;
    logic                       arstN_i;
    logic [`SCROLL_LEVEL_W-1:0] level_i;
    playerState_t               player_i;
    laneArray_t                 lanes_o;
    logic                       hit_o;

    int tickCount  = 0;
    int cycleCount = 0;
    int seed       = 64;

    scrollTop dut (
        .btnClk   (btnClk),
        .arstN_i  (arstN_i),
        .level_i  (level_i),
        .player_i (player_i),
        .lanes_o  (lanes_o),
        .hit_o    (hit_o)
    );

    always #10 btnClk = ~btnClk;

    // edges seen by the offset counters out of reset
    always @(posedge btnClk) begin
        if (arstN_i) begin
            tickCount <= tickCount + 1;
        end
    end

    always @(posedge btnClk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $fatal(1, "simulation timed out");
        end
    end

    // ============================================================
    // reference model
    // ============================================================
    function automatic int expOffset(input int lane, input int ticks);
        return (ticks * int'(laneSpeed(lane))) % SCREEN_W;
    endfunction

    function automatic bit expVisible(input int level, input int lane);
        if (level <= NUM_LANES - 1) begin
            return lane <= level;
        end
        return lane == 1;
    endfunction

    function automatic bit expHit(input playerState_t p, input int level, input int ticks);
        int  left;
        int  top;
        int  pl;
        int  pt;
        bit  hit;
        hit = 1'b0;
        pl  = int'(p.hPos);
        pt  = int'(p.vPos);
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int b = 0; b < NUM_BARS; b++) begin
                left = (int'(barBase(l, b)) + expOffset(l, ticks)) % SCREEN_W;
                top  = int'(laneTop(l));
                if (expVisible(level, l) && pl < left + int'(barWidth(l))
                        && left < pl + PLAYER_SIZE && pt < top + ROW_H
                        && top < pt + PLAYER_SIZE && p.color != barColor(l, b)) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    // ============================================================
    // helpers
    // ============================================================
    task automatic checkValue(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic stepCycle();
        @(posedge btnClk);
        #1;
    endtask

    task automatic placePlayer(input int h, input int v, input int c);
        player_i.hPos  = coord_t'(h);
        player_i.vPos  = coord_t'(v);
        player_i.color = color_t'(c);
    endtask

    task automatic checkOffsets();
        for (int n = 0; n < NUM_LANES; n++) begin
            checkValue($sformatf("lanes_o[%0d].offset", n), int'(lanes_o[n].offset),
                       expOffset(n, tickCount));
        end
    endtask

    // ============================================================
    // tests
    // ============================================================
    task automatic testReset();
        checkOffsets();
        for (int n = 0; n < NUM_LANES; n++) begin
            checkValue($sformatf("lanes_o[%0d].offset", n), int'(lanes_o[n].offset), 0);
        end
        checkValue("hit_o", int'(hit_o), 0);
    endtask

    task automatic testScroll();
        int finalOffset [NUM_LANES] = '{20, 330, 20, 330, 20, 0};
        while (tickCount < 330) begin
            stepCycle();
            // dense around the first wrap of the fast lanes
            if (tickCount % 10 == 0 || (tickCount >= 318 && tickCount <= 322)) begin
                checkOffsets();
            end
        end
        for (int n = 0; n < NUM_LANES; n++) begin
            checkValue($sformatf("lanes_o[%0d].offset", n), int'(lanes_o[n].offset),
                       finalOffset[n]);
        end
    endtask

    task automatic testLevels();
        for (int lvl = 0; lvl < 8; lvl++) begin
            stepCycle();
            level_i = lvl[`SCROLL_LEVEL_W-1:0];
            #1;
            for (int n = 0; n < NUM_LANES; n++) begin
                checkValue($sformatf("lanes_o[%0d].visible at level %0d", n, lvl),
                           int'(lanes_o[n].visible), int'(expVisible(lvl, n)));
            end
        end
        stepCycle();
    endtask

    // player sits 10 pixels into bar 0 of lane 0 at the current offset
    task automatic directedCase(input int level, input int v, input int color,
                                input int expected, input string label);
        int left;
        left    = (int'(barBase(0, 0)) + expOffset(0, tickCount)) % SCREEN_W;
        level_i = level[`SCROLL_LEVEL_W-1:0];
        placePlayer(left + 10, v, color);
        stepCycle();
        checkValue($sformatf("hit_o (%s)", label), int'(hit_o), expected);
    endtask

    task automatic testDirected();
        directedCase(5, int'(laneTop(0)), 7, 1, "other color");
        directedCase(5, int'(laneTop(0)), int'(barColor(0, 0)), 0, "own color");
        directedCase(6, int'(laneTop(0)), 7, 0, "lane hidden");
        directedCase(5, 90, 7, 0, "between lanes");
    endtask

    task automatic testRandom();
        int  lane;
        int  h;
        int  v;
        int  c;
        bit  expected;
        level_i = 3'd5;
        for (int i = 0; i < 40; i++) begin
            lane = $unsigned($random(seed)) % NUM_LANES;
            v    = int'(laneTop(lane)) + $unsigned($random(seed)) % 24 - 12;
            h    = $unsigned($random(seed)) % 700;
            c    = $unsigned($random(seed)) % 6;
            placePlayer(h, v, c);
            expected = expHit(player_i, 5, tickCount);
            stepCycle();
            checkValue($sformatf("hit_o (random %0d)", i), int'(hit_o), int'(expected));
        end
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        arstN_i  = 1'b0;
        level_i  = 3'd5;
        player_i = '0;
        repeat (3) @(posedge btnClk);
        #1;
        arstN_i = 1'b1;

        testReset();
        testScroll();
        testLevels();
        testDirected();
        testRandom();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/scrollTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scrollField_params.svh"

module scrollTop (
    input  wire logic                      btnClk,
    input  wire logic                      arstN_i,
    input  wire logic [`SCROLL_LEVEL_W-1:0] level_i,
    input  wire scrollPkg::playerState_t    player_i,
    output scrollPkg::laneArray_t          lanes_o,
    output logic                           hit_o
);

    import scrollPkg::*;

    // lane state shared by the collision logic and the output
    laneArray_t lanes;

    // ============================================================
    // lane producer
    // ============================================================
    laneField uLaneField (
        .btnClk  (btnClk),
        .arstN_i (arstN_i),
        .level_i (level_i),
        .lanes_o (lanes)
    );

    // ============================================================
    // collision consumer
    // ============================================================
    collisionCheck uCollisionCheck (
        .btnClk   (btnClk),
        .arstN_i  (arstN_i),
        .lanes_i  (lanes),
        .player_i (player_i),
        .hit_o    (hit_o)
    );

    assign lanes_o = lanes;

endmodule

`default_nettype wire

// ==== src/collisionCheck.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scrollField_params.svh"

module collisionCheck (
    input  wire logic                   btnClk,
    input  wire logic                   arstN_i,
    input  wire scrollPkg::laneArray_t   lanes_i,
    input  wire scrollPkg::playerState_t player_i,
    output logic                        hit_o
);

    import scrollPkg::*;

    localparam int NUM_LANES = `SCROLL_NUM_LANES;
    localparam int NUM_BARS  = `SCROLL_BARS_PER_LANE;

    // one spare bit so edges past the screen do not wrap
    typedef logic [`SCROLL_COORD_W:0] wideCoord_t;

    localparam wideCoord_t SCREEN_W    = wideCoord_t'(`SCROLL_SCREEN_W);
    localparam wideCoord_t ROW_H       = wideCoord_t'(`SCROLL_ROW_H);
    localparam wideCoord_t PLAYER_SIZE = wideCoord_t'(`SCROLL_PLAYER_SIZE);

    wideCoord_t playerLeft;
    wideCoord_t playerRight;
    wideCoord_t playerTop;
    wideCoord_t playerBottom;

    logic [NUM_LANES*NUM_BARS-1:0] barHit;

    // ============================================================
    // player box
    // ============================================================
    assign playerLeft   = {1'b0, player_i.hPos};
    assign playerTop    = {1'b0, player_i.vPos};
    assign playerRight  = playerLeft + PLAYER_SIZE;
    assign playerBottom = playerTop + PLAYER_SIZE;

    // ============================================================
    // bar boxes and per bar hit
    // ============================================================
    for (genvar l = 0; l < NUM_LANES; l++) begin : gLane
        for (genvar b = 0; b < NUM_BARS; b++) begin : gBar

            localparam wideCoord_t BASE  = wideCoord_t'(barBase(l, b));
            localparam wideCoord_t WIDTH = wideCoord_t'(barWidth(l));
            localparam wideCoord_t TOP   = wideCoord_t'(laneTop(l));
            localparam color_t     COLOR = barColor(l, b);

            wideCoord_t sum;
            wideCoord_t left;
            wideCoord_t right;
            logic       hOverlap;
            logic       vOverlap;

            // base and offset both stay below the screen width so one subtract wraps
            assign sum   = BASE + {1'b0, lanes_i[l].offset};
            assign left  = (sum >= SCREEN_W) ? sum - SCREEN_W : sum;
            assign right = left + WIDTH;

            // the span is not wrapped and may run past the right border
            assign hOverlap = (playerLeft < right) && (left < playerRight);
            assign vOverlap = (playerTop < TOP + ROW_H) && (TOP < playerBottom);

            // same color as the bar is a safe landing
            assign barHit[l*NUM_BARS + b] = lanes_i[l].visible && hOverlap && vOverlap
                                            && (player_i.color != COLOR);
        end
    end

    // ============================================================
    // hit register
    // ============================================================
    always_ff @(posedge btnClk or negedge arstN_i) begin
        if (!arstN_i) begin
            hit_o <= 1'b0;
        end else begin
            hit_o <= |barHit;
        end
    end

endmodule

`default_nettype wire

// ==== src/laneField.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scrollField_params.svh"

module laneField (
    input  wire logic                      btnClk,
    input  wire logic                      arstN_i,
    input  wire logic [`SCROLL_LEVEL_W-1:0] level_i,
    output scrollPkg::laneArray_t          lanes_o
);

    import scrollPkg::*;

    localparam int     NUM_LANES = `SCROLL_NUM_LANES;
    localparam int     LAST_LANE = NUM_LANES - 1;
    localparam coord_t SCREEN_W  = coord_t'(`SCROLL_SCREEN_W);

    logic [NUM_LANES-1:0] visible;

    // ============================================================
    // level decode
    // ============================================================

    // level L shows lanes 0..L
    // levels past the last lane fall back to lane 1 alone
    always_comb begin
        for (int n = 0; n < NUM_LANES; n++) begin
            if (level_i <= LAST_LANE) begin
                visible[n] = (n <= level_i);
            end else begin
                visible[n] = (n == 1);
            end
        end
    end

    // ============================================================
    // per lane offset counters
    // ============================================================

    for (genvar n = 0; n < NUM_LANES; n++) begin : gLane

        localparam coord_t SPEED = laneSpeed(n);

        coord_t offset;
        coord_t stepped;

        // offset stays below the screen width so one step never overflows the word
        assign stepped = offset + SPEED;

        always_ff @(posedge btnClk or negedge arstN_i) begin
            if (!arstN_i) begin
                offset <= '0;
            end else if (stepped >= SCREEN_W) begin
                offset <= stepped - SCREEN_W;
            end else begin
                offset <= stepped;
            end
        end

        // counters run even while the lane is hidden
        assign lanes_o[n] = '{visible: visible[n], offset: offset};

    end

endmodule

`default_nettype wire

// ==== src/scrollPkg.sv ====
`default_nettype none

`include "scrollField_params.svh"

package scrollPkg;

    typedef logic [`SCROLL_COORD_W-1:0] coord_t;
    typedef logic [`SCROLL_COLOR_W-1:0] color_t;

    typedef struct packed {
        coord_t hPos;
        coord_t vPos;
        color_t color;
    } playerState_t;

    typedef struct packed {
        logic   visible;
        coord_t offset;
    } laneState_t;

    typedef laneState_t [`SCROLL_NUM_LANES-1:0] laneArray_t;

    // ============================================================
    // lane table
    // ============================================================

    // pixels per btnClk tick with the last lane standing still
    function automatic coord_t laneSpeed(input int lane);
        case (lane)
            0, 2, 4: return coord_t'(2);
            1, 3:    return coord_t'(1);
            default: return '0;
        endcase
    endfunction

    // top pixel row of a lane
    function automatic coord_t laneTop(input int lane);
        int row;
        case (lane)
            0:       row = 5;
            1:       row = 10;
            2:       row = 17;
            3:       row = 22;
            4:       row = 29;
            default: row = 34;
        endcase
        return coord_t'(row * `SCROLL_ROW_H);
    endfunction

    // unscrolled left edge of a bar
    // short bars sit packed after one long bar slot
    function automatic coord_t barBase(input int lane, input int bar);
        if (lane == `SCROLL_NUM_LANES - 1) begin
            return coord_t'(`SCROLL_BAR_W + `SCROLL_SMALL_BAR_W * (bar + 1));
        end
        return coord_t'(`SCROLL_BAR_W * (bar + 1));
    endfunction

    function automatic coord_t barWidth(input int lane);
        if (lane == `SCROLL_NUM_LANES - 1) begin
            return coord_t'(`SCROLL_SMALL_BAR_W);
        end
        return coord_t'(`SCROLL_BAR_W);
    endfunction

    // bars run red, cyan, yellow and magenta
    // the last short bar is red again
    function automatic color_t barColor(input int lane, input int bar);
        if (lane == `SCROLL_NUM_LANES - 1 && bar == `SCROLL_BARS_PER_LANE - 1) begin
            return color_t'(2);
        end
        return color_t'(bar + 2);
    endfunction

endpackage

`default_nettype wire

// ==== src/scrollField_params.svh ====
`ifndef SCROLL_FIELD_PARAMS_SVH
`define SCROLL_FIELD_PARAMS_SVH

// ============================================================
// word widths
// ============================================================
`define SCROLL_COORD_W 10
`define SCROLL_COLOR_W 4
`define SCROLL_LEVEL_W 3

// ============================================================
// lane field layout
// ============================================================
`define SCROLL_NUM_LANES 6
`define SCROLL_BARS_PER_LANE 4

// every lane offset wraps here
`define SCROLL_SCREEN_W 640

// one grid row, also the height of every bar
`define SCROLL_ROW_H 12

// long bars in lanes 0 to 4
`define SCROLL_BAR_W 128

// short bars of the last lane
`define SCROLL_SMALL_BAR_W 12

// player is a square of this side
`define SCROLL_PLAYER_SIZE 12

`endif
